// ==== Makefile ====
VERILATOR   ?= verilator
TOP         := arm_dp_tb
FILELIST    := arm_dp.f
LINT_FLAGS  := --lint-only --timing --assert
SIM_FLAGS   := --binary --timing --assert
OBJ_DIR     := obj_dir
LOG         := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== arm_dp.f ====
+incdir+common
common/arm_dp_pkg.sv
common/dx_if.sv
execute/barrel_shift.sv
decode/decode_stage.sv
execute/execute_stage.sv
result/result_stage.sv
result/reg_file.sv
hdl/arm_dp_top.sv
tests/arm_dp_tb.sv

// ==== common/arm_dp_macros.svh ====
`ifndef ARM_DP_MACROS_SVH
`define ARM_DP_MACROS_SVH

// datapath widths
`define ARM_DP_XLEN     32
`define ARM_DP_REG_AW   4
`define ARM_DP_IMM_W    8
`define ARM_DP_SHAMT_W  5

// data-processing opcodes, instr[24:21]
`define ARM_DP_OP_AND   4'b0000
`define ARM_DP_OP_EOR   4'b0001
`define ARM_DP_OP_SUB   4'b0010
`define ARM_DP_OP_ADD   4'b0100
`define ARM_DP_OP_CMP   4'b1010
`define ARM_DP_OP_ORR   4'b1100
`define ARM_DP_OP_MOV   4'b1101

// condition field, instr[31:28]
`define ARM_DP_COND_EQ  4'b0000
`define ARM_DP_COND_NE  4'b0001
`define ARM_DP_COND_CS  4'b0010
`define ARM_DP_COND_CC  4'b0011
`define ARM_DP_COND_MI  4'b0100
`define ARM_DP_COND_PL  4'b0101
`define ARM_DP_COND_VS  4'b0110
`define ARM_DP_COND_VC  4'b0111
`define ARM_DP_COND_HI  4'b1000
`define ARM_DP_COND_LS  4'b1001
`define ARM_DP_COND_GE  4'b1010
`define ARM_DP_COND_LT  4'b1011
`define ARM_DP_COND_GT  4'b1100
`define ARM_DP_COND_LE  4'b1101
`define ARM_DP_COND_AL  4'b1110

`endif

// ==== common/arm_dp_pkg.sv ====
`include "arm_dp_macros.svh"

package arm_dp_pkg;

    // data word and register index
    typedef logic [`ARM_DP_XLEN-1:0]    word_t;
    typedef logic [`ARM_DP_REG_AW-1:0]  reg_addr_t;

    // instruction fields
    typedef logic [3:0]                 opcode_t;
    typedef logic [3:0]                 cond_t;

    // shift type: 00 lsl, 01 lsr, 10 asr, 11 ror
    typedef logic [1:0]                 shift_t;
    typedef logic [`ARM_DP_SHAMT_W-1:0] shamt_t;

    // {n, z, c, v}
    typedef logic [3:0]                 flags_t;

endpackage

// ==== common/dx_if.sv ====
`timescale 1ns/1ps

interface dx_if import arm_dp_pkg::*; ();

    logic      valid;
    cond_t     cond;
    opcode_t   opcode;
    logic      set_flags;
    logic      writes_reg;
    reg_addr_t rd;
    reg_addr_t rn_addr;
    reg_addr_t rm_addr;
    // register file values, forwarding applied in execute
    word_t     rn_val;
    word_t     rm_val;
    logic      use_imm;
    word_t     imm;
    shift_t    sh_type;
    shamt_t    shamt;

    modport decode (
        output valid, cond, opcode, set_flags, writes_reg, rd,
        output rn_addr, rm_addr, rn_val, rm_val, use_imm, imm, sh_type, shamt
    );

    modport execute (
        input valid, cond, opcode, set_flags, writes_reg, rd,
        input rn_addr, rm_addr, rn_val, rm_val, use_imm, imm, sh_type, shamt
    );

endinterface

// ==== decode/decode_stage.sv ====
`timescale 1ns/1ps
`include "arm_dp_macros.svh"

module decode_stage import arm_dp_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      instr_valid,
    input  word_t     instr,
    output reg_addr_t rn_addr,
    output reg_addr_t rm_addr,
    input  word_t     rn_val,
    input  word_t     rm_val,
    dx_if.decode      dx
);

    logic    valid_q;
    word_t   instr_q;
    opcode_t opcode;
    logic    known_op;
    logic    writes_op;
    logic    is_cmp;

    // instruction register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q <= 1'b0;
            instr_q <= '0;
        end else begin
            valid_q <= instr_valid;
            instr_q <= instr;
        end
    end

    ////////////////////
    // field decode
    assign opcode = instr_q[24:21];
    assign is_cmp = (opcode == `ARM_DP_OP_CMP);

    always_comb begin
        case (opcode)
            `ARM_DP_OP_AND, `ARM_DP_OP_EOR, `ARM_DP_OP_SUB,
            `ARM_DP_OP_ADD, `ARM_DP_OP_ORR, `ARM_DP_OP_MOV: begin
                known_op  = 1'b1;
                writes_op = 1'b1;
            end
            // compare only, no destination
            `ARM_DP_OP_CMP: begin
                known_op  = 1'b1;
                writes_op = 1'b0;
            end
            default: begin
                known_op  = 1'b0;
                writes_op = 1'b0;
            end
        endcase
    end

    // register read ports, rn and rm
    assign rn_addr = instr_q[19:16];
    assign rm_addr = instr_q[3:0];

    assign dx.valid      = valid_q;
    assign dx.cond       = instr_q[31:28];
    assign dx.opcode     = opcode;
    assign dx.set_flags  = is_cmp | (instr_q[20] & known_op);
    assign dx.writes_reg = writes_op;
    assign dx.rd         = instr_q[15:12];
    assign dx.rn_addr    = rn_addr;
    assign dx.rm_addr    = rm_addr;
    assign dx.rn_val     = rn_val;
    assign dx.rm_val     = rm_val;
    assign dx.use_imm    = instr_q[25];
    // rotate field ignored, plain zero-extended byte
    assign dx.imm = {{(`ARM_DP_XLEN-`ARM_DP_IMM_W){1'b0}}, instr_q[`ARM_DP_IMM_W-1:0]};
    assign dx.sh_type    = instr_q[6:5];
    assign dx.shamt      = instr_q[11:7];

    a_opcode_known: assert property (
        @(posedge clk) disable iff (reset) dx.valid |-> !$isunknown(dx.opcode)
    );

endmodule

// ==== execute/barrel_shift.sv ====
`timescale 1ns/1ps
`include "arm_dp_macros.svh"

module barrel_shift import arm_dp_pkg::*; (
    input  word_t  value,
    input  shift_t sh_type,
    input  shamt_t shamt,
    output word_t  shifted
);

    logic [2*`ARM_DP_XLEN-1:0] rot;

    // rotate as a shift of the doubled word
    assign rot = {value, value} >> shamt;

    always_comb begin
        if (shamt == '0) begin
            // amount 0 is no shift for every type
            shifted = value;
        end else begin
            case (sh_type)
                // lsl
                2'b00: shifted = value << shamt;
                // lsr
                2'b01: shifted = value >> shamt;
                // asr, sign fill
                2'b10: shifted = word_t'($signed(value) >>> shamt);
                // ror
                default: shifted = rot[`ARM_DP_XLEN-1:0];
            endcase
        end
    end

endmodule

// ==== execute/execute_stage.sv ====
`timescale 1ns/1ps
`include "arm_dp_macros.svh"

module execute_stage import arm_dp_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    dx_if.execute     dx,
    input  logic      wr_valid,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data,
    output logic      res_valid,
    output reg_addr_t res_addr,
    output word_t     res_data,
    output flags_t    flags
);

    logic      valid_q, set_flags_q, writes_reg_q, use_imm_q;
    cond_t     cond_q;
    opcode_t   opcode_q;
    reg_addr_t rd_q, rn_addr_q, rm_addr_q;
    word_t     rn_val_q, rm_val_q, imm_q;
    shift_t    sh_type_q;
    shamt_t    shamt_q;

    word_t     op_a, op_b_reg, op_b_shifted, op_b;
    logic [`ARM_DP_XLEN:0] sum, diff;
    word_t     result;
    flags_t    new_flags;
    logic      pass;

    ////////////////////
    // execute register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q <= 1'b0;
            set_flags_q <= 1'b0;
            writes_reg_q <= 1'b0;
            use_imm_q <= 1'b0;
            cond_q <= '0;
            opcode_q <= '0;
            rd_q <= '0;
            rn_addr_q <= '0;
            rm_addr_q <= '0;
            rn_val_q <= '0;
            rm_val_q <= '0;
            imm_q <= '0;
            sh_type_q <= '0;
            shamt_q <= '0;
        end else begin
            valid_q <= dx.valid;
            set_flags_q <= dx.set_flags;
            writes_reg_q <= dx.writes_reg;
            use_imm_q <= dx.use_imm;
            cond_q <= dx.cond;
            opcode_q <= dx.opcode;
            rd_q <= dx.rd;
            rn_addr_q <= dx.rn_addr;
            rm_addr_q <= dx.rm_addr;
            rn_val_q <= dx.rn_val;
            rm_val_q <= dx.rm_val;
            imm_q <= dx.imm;
            sh_type_q <= dx.sh_type;
            shamt_q <= dx.shamt;
        end
    end

    // forward from the writeback register
    assign op_a     = (wr_valid && wr_addr == rn_addr_q) ? wr_data : rn_val_q;
    assign op_b_reg = (wr_valid && wr_addr == rm_addr_q) ? wr_data : rm_val_q;

    barrel_shift barrel_shift_i (
        .value   (op_b_reg),
        .sh_type (sh_type_q),
        .shamt   (shamt_q),
        .shifted (op_b_shifted)
    );

    assign op_b = use_imm_q ? imm_q : op_b_shifted;

    ////////////////////
    // alu
    assign sum  = {1'b0, op_a} + {1'b0, op_b};
    // carry out of a + ~b + 1 is the not-borrow
    assign diff = {1'b0, op_a} + {1'b0, ~op_b} + {{`ARM_DP_XLEN{1'b0}}, 1'b1};

    always_comb begin
        result = '0;
        new_flags = flags;
        case (opcode_q)
            `ARM_DP_OP_AND: result = op_a & op_b;
            `ARM_DP_OP_EOR: result = op_a ^ op_b;
            `ARM_DP_OP_ORR: result = op_a | op_b;
            `ARM_DP_OP_MOV: result = op_b;
            `ARM_DP_OP_ADD: result = sum[`ARM_DP_XLEN-1:0];
            `ARM_DP_OP_SUB, `ARM_DP_OP_CMP: result = diff[`ARM_DP_XLEN-1:0];
            default: result = '0;
        endcase
        // n and z from every op
        // c and v only from arithmetic
        new_flags[3] = result[`ARM_DP_XLEN-1];
        new_flags[2] = (result == '0);
        if (opcode_q == `ARM_DP_OP_ADD) begin
            new_flags[1] = sum[`ARM_DP_XLEN];
            new_flags[0] = (op_a[`ARM_DP_XLEN-1] == op_b[`ARM_DP_XLEN-1]) &&
                           (result[`ARM_DP_XLEN-1] != op_a[`ARM_DP_XLEN-1]);
        end else if (opcode_q == `ARM_DP_OP_SUB || opcode_q == `ARM_DP_OP_CMP) begin
            new_flags[1] = diff[`ARM_DP_XLEN];
            new_flags[0] = (op_a[`ARM_DP_XLEN-1] != op_b[`ARM_DP_XLEN-1]) &&
                           (result[`ARM_DP_XLEN-1] != op_a[`ARM_DP_XLEN-1]);
        end
    end

    // condition check against the stored flags
    always_comb begin
        case (cond_q)
            `ARM_DP_COND_EQ: pass = flags[2];
            `ARM_DP_COND_NE: pass = !flags[2];
            `ARM_DP_COND_CS: pass = flags[1];
            `ARM_DP_COND_CC: pass = !flags[1];
            `ARM_DP_COND_MI: pass = flags[3];
            `ARM_DP_COND_PL: pass = !flags[3];
            `ARM_DP_COND_VS: pass = flags[0];
            `ARM_DP_COND_VC: pass = !flags[0];
            `ARM_DP_COND_HI: pass = flags[1] && !flags[2];
            `ARM_DP_COND_LS: pass = !flags[1] || flags[2];
            `ARM_DP_COND_GE: pass = (flags[3] == flags[0]);
            `ARM_DP_COND_LT: pass = (flags[3] != flags[0]);
            `ARM_DP_COND_GT: pass = !flags[2] && (flags[3] == flags[0]);
            `ARM_DP_COND_LE: pass = flags[2] || (flags[3] != flags[0]);
            `ARM_DP_COND_AL: pass = 1'b1;
            // 1111 never executes
            default: pass = 1'b0;
        endcase
    end

    // nzcv register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flags <= '0;
        end else if (valid_q && pass && set_flags_q) begin
            flags <= new_flags;
        end
    end

    assign res_valid = valid_q && pass && writes_reg_q;
    assign res_addr  = rd_q;
    assign res_data  = result;

    a_res_addr_known: assert property (
        @(posedge clk) disable iff (reset) res_valid |-> !$isunknown(res_addr)
    );

endmodule

// ==== hdl/arm_dp_top.sv ====
`timescale 1ns/1ps

module arm_dp_top import arm_dp_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      instr_valid,
    input  word_t     instr,
    output logic      wb_valid,
    output reg_addr_t wb_addr,
    output word_t     wb_data,
    output flags_t    flags
);

    reg_addr_t rn_addr, rm_addr;
    word_t     rn_val, rm_val;
    logic      res_valid;
    reg_addr_t res_addr;
    word_t     res_data;

    dx_if dx ();

    ////////////////////
    // decode
    decode_stage decode_stage_i (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rn_addr     (rn_addr),
        .rm_addr     (rm_addr),
        .rn_val      (rn_val),
        .rm_val      (rm_val),
        .dx          (dx.decode)
    );

    ////////////////////
    // execute, forwarding from the wb ports
    execute_stage execute_stage_i (
        .clk       (clk),
        .reset     (reset),
        .dx        (dx.execute),
        .wr_valid  (wb_valid),
        .wr_addr   (wb_addr),
        .wr_data   (wb_data),
        .res_valid (res_valid),
        .res_addr  (res_addr),
        .res_data  (res_data),
        .flags     (flags)
    );

    ////////////////////
    // writeback
    result_stage result_stage_i (
        .clk       (clk),
        .reset     (reset),
        .res_valid (res_valid),
        .res_addr  (res_addr),
        .res_data  (res_data),
        .wr_valid  (wb_valid),
        .wr_addr   (wb_addr),
        .wr_data   (wb_data)
    );

    reg_file reg_file_i (
        .clk      (clk),
        .reset    (reset),
        .wr_valid (wb_valid),
        .wr_addr  (wb_addr),
        .wr_data  (wb_data),
        .rn_addr  (rn_addr),
        .rm_addr  (rm_addr),
        .rn_val   (rn_val),
        .rm_val   (rm_val)
    );

endmodule

// ==== result/reg_file.sv ====
`timescale 1ns/1ps
`include "arm_dp_macros.svh"

module reg_file import arm_dp_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      wr_valid,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data,
    input  reg_addr_t rn_addr,
    input  reg_addr_t rm_addr,
    output word_t     rn_val,
    output word_t     rm_val
);

    localparam int NUM_REGS = 1 << `ARM_DP_REG_AW;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_valid) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // write-through read returns the value being written
    assign rn_val = (wr_valid && wr_addr == rn_addr) ? wr_data : regs[rn_addr];
    assign rm_val = (wr_valid && wr_addr == rm_addr) ? wr_data : regs[rm_addr];

    a_wr_addr_known: assert property (
        @(posedge clk) disable iff (reset) wr_valid |-> !$isunknown(wr_addr)
    );

endmodule

// ==== result/result_stage.sv ====
`timescale 1ns/1ps

module result_stage import arm_dp_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      res_valid,
    input  reg_addr_t res_addr,
    input  word_t     res_data,
    output logic      wr_valid,
    output reg_addr_t wr_addr,
    output word_t     wr_data
);

    // writeback register
    // feeds the register file write port and the execute forward path
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_valid <= 1'b0;
            wr_addr <= '0;
            wr_data <= '0;
        end else begin
            wr_valid <= res_valid;
            wr_addr <= res_addr;
            wr_data <= res_data;
        end
    end

endmodule

// ==== tests/arm_dp_tb.sv ====
`timescale 1ns/1ps
`include "arm_dp_macros.svh"

module arm_dp_tb import arm_dp_pkg::*; ();

    localparam int MAX_ENTRIES = 320;
    localparam int RAND_COUNT = 200;

    logic      clk;
    logic      reset;
    logic      instr_valid;
    word_t     instr;
    logic      wb_valid;
    reg_addr_t wb_addr;
    word_t     wb_data;
    flags_t    flags;

    // stimulus and expected values per cycle
    logic      tbl_valid [MAX_ENTRIES];
    word_t     tbl_instr [MAX_ENTRIES];
    logic      tbl_wv [MAX_ENTRIES];
    reg_addr_t tbl_wa [MAX_ENTRIES];
    word_t     tbl_wd [MAX_ENTRIES];
    flags_t    tbl_fl [MAX_ENTRIES];
    int        tbl_count;

    // reference model state
    word_t     model_regs [16];
    flags_t    model_flags;

    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          tests_run;

    arm_dp_top arm_dp_top_i (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .flags       (flags)
    );

    always #2 clk = ~clk;

    ////////////////////
    // helpers
    task automatic check(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    function automatic word_t enc_imm(input cond_t c, input opcode_t op, input logic s,
                                      input reg_addr_t rd, input reg_addr_t rn,
                                      input logic [7:0] imm8);
        return {c, 2'b00, 1'b1, op, s, rn, rd, 4'h0, imm8};
    endfunction

    function automatic word_t enc_reg(input cond_t c, input opcode_t op, input logic s,
                                      input reg_addr_t rd, input reg_addr_t rn,
                                      input reg_addr_t rm, input shift_t sh,
                                      input shamt_t amt);
        return {c, 2'b00, 1'b0, op, s, rn, rd, amt, sh, 1'b0, rm};
    endfunction

    // galois lfsr stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic add(input logic v, input word_t ins, input logic ev,
                       input reg_addr_t ea, input word_t ed, input flags_t ef);
        tbl_valid[tbl_count] = v;
        tbl_instr[tbl_count] = ins;
        tbl_wv[tbl_count] = ev;
        tbl_wa[tbl_count] = ea;
        tbl_wd[tbl_count] = ed;
        tbl_fl[tbl_count] = ef;
        tbl_count++;
    endtask

    // sequential model of the pipeline with complete forwarding
    task automatic model_exec(input logic v, input word_t ins);
        logic        n, z, c, ov, pass, writes, set;
        opcode_t     op;
        word_t       a, b, r;
        logic [32:0] wide;
        n = model_flags[3];
        z = model_flags[2];
        c = model_flags[1];
        ov = model_flags[0];
        case (ins[31:28])
            4'h0: pass = z;
            4'h1: pass = !z;
            4'h2: pass = c;
            4'h3: pass = !c;
            4'h4: pass = n;
            4'h5: pass = !n;
            4'h6: pass = ov;
            4'h7: pass = !ov;
            4'h8: pass = c && !z;
            4'h9: pass = !c || z;
            4'ha: pass = (n == ov);
            4'hb: pass = (n != ov);
            4'hc: pass = !z && (n == ov);
            4'hd: pass = z || (n != ov);
            4'he: pass = 1'b1;
            default: pass = 1'b0;
        endcase
        op = ins[24:21];
        a = model_regs[ins[19:16]];
        if (ins[25]) begin
            b = {24'h0, ins[7:0]};
        end else begin
            b = model_regs[ins[3:0]];
            // one bit position per step
            for (int k = 0; k < ins[11:7]; k++) begin
                case (ins[6:5])
                    2'b00: b = {b[30:0], 1'b0};
                    2'b01: b = {1'b0, b[31:1]};
                    2'b10: b = {b[31], b[31:1]};
                    default: b = {b[0], b[31:1]};
                endcase
            end
        end
        r = '0;
        case (op)
            `ARM_DP_OP_AND: r = a & b;
            `ARM_DP_OP_EOR: r = a ^ b;
            `ARM_DP_OP_ORR: r = a | b;
            `ARM_DP_OP_MOV: r = b;
            `ARM_DP_OP_ADD: begin
                wide = {1'b0, a} + {1'b0, b};
                r = wide[31:0];
                c = wide[32];
                ov = (a[31] == b[31]) && (r[31] != a[31]);
            end
            `ARM_DP_OP_SUB, `ARM_DP_OP_CMP: begin
                r = a - b;
                c = (a >= b);
                ov = (a[31] != b[31]) && (r[31] != a[31]);
            end
            default: r = '0;
        endcase
        writes = (op != `ARM_DP_OP_CMP);
        set = ins[20] || (op == `ARM_DP_OP_CMP);
        if (v && pass && set) begin
            model_flags = {r[31], (r == 0), c, ov};
        end
        if (v && pass && writes) begin
            model_regs[ins[15:12]] = r;
        end
        add(v, ins, v && pass && writes, ins[15:12], r, model_flags);
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    // drive one entry per cycle and check it three edges later
    task automatic run_block(input int first, input int count, input string name);
        int e;
        int err0;
        err0 = errors;
        for (int t = 0; t < count + 3; t++) begin
            @(posedge clk);
            #1;
            if (t >= 3) begin
                e = first + t - 3;
                check($sformatf("wb_valid[%0d]", e), word_t'(wb_valid), word_t'(tbl_wv[e]));
                check($sformatf("flags[%0d]", e), word_t'(flags), word_t'(tbl_fl[e]));
                if (tbl_wv[e]) begin
                    check($sformatf("wb_addr[%0d]", e), word_t'(wb_addr), word_t'(tbl_wa[e]));
                    check($sformatf("wb_data[%0d]", e), wb_data, tbl_wd[e]);
                end
            end
            if (t < count) begin
                instr_valid = tbl_valid[first + t];
                instr = tbl_instr[first + t];
            end else begin
                instr_valid = 1'b0;
                instr = '0;
            end
        end
        tests_run++;
        $display("test %-12s %0d entries, %0d errors", name, count, errors - err0);
    endtask

    ////////////////////
    // directed table
    task automatic fill_table();
        cond_t al;
        al = `ARM_DP_COND_AL;
        tbl_count = 0;
        // 0..5 idle after reset
        for (int i = 0; i < 6; i++) add(1'b0, '0, 1'b0, 4'h0, '0, 4'h0);
        // 6..12 immediate ops
        add(1, enc_imm(al, `ARM_DP_OP_MOV, 0, 1, 0, 8'h5a), 1, 1, 32'h5a, 4'h0);
        add(1, enc_imm(al, `ARM_DP_OP_MOV, 0, 2, 0, 8'h0f), 1, 2, 32'h0f, 4'h0);
        add(1, enc_imm(al, `ARM_DP_OP_ADD, 0, 3, 1, 8'h10), 1, 3, 32'h6a, 4'h0);
        add(1, enc_imm(al, `ARM_DP_OP_SUB, 0, 4, 2, 8'h05), 1, 4, 32'h0a, 4'h0);
        add(1, enc_imm(al, `ARM_DP_OP_AND, 0, 5, 1, 8'hf0), 1, 5, 32'h50, 4'h0);
        add(1, enc_imm(al, `ARM_DP_OP_EOR, 0, 6, 1, 8'hff), 1, 6, 32'ha5, 4'h0);
        add(1, enc_imm(al, `ARM_DP_OP_ORR, 0, 7, 2, 8'h30), 1, 7, 32'h3f, 4'h0);
        // 13..17 dependencies at distance one, two and three
        add(1, enc_imm(al, `ARM_DP_OP_MOV, 0, 8, 0, 8'h11), 1, 8, 32'h11, 4'h0);
        add(1, enc_imm(al, `ARM_DP_OP_ADD, 0, 9, 8, 8'h01), 1, 9, 32'h12, 4'h0);
        add(1, enc_imm(al, `ARM_DP_OP_ADD, 0, 10, 8, 8'h02), 1, 10, 32'h13, 4'h0);
        add(1, enc_imm(al, `ARM_DP_OP_ADD, 0, 11, 8, 8'h03), 1, 11, 32'h14, 4'h0);
        add(1, enc_reg(al, `ARM_DP_OP_ADD, 0, 9, 9, 9, 2'b00, 0), 1, 9, 32'h24, 4'h0);
        // 18..27 shifted register operands
        add(1, enc_imm(al, `ARM_DP_OP_MOV, 0, 12, 0, 8'h81), 1, 12, 32'h81, 4'h0);
        add(1, enc_reg(al, `ARM_DP_OP_MOV, 0, 0, 0, 12, 2'b00, 4), 1, 0, 32'h810, 4'h0);
        add(1, enc_reg(al, `ARM_DP_OP_MOV, 0, 0, 0, 12, 2'b00, 0), 1, 0, 32'h81, 4'h0);
        add(1, enc_reg(al, `ARM_DP_OP_MOV, 0, 13, 0, 12, 2'b00, 24), 1, 13, 32'h81000000, 4'h0);
        add(1, enc_reg(al, `ARM_DP_OP_MOV, 0, 0, 0, 12, 2'b01, 3), 1, 0, 32'h10, 4'h0);
        add(1, enc_reg(al, `ARM_DP_OP_MOV, 0, 0, 0, 13, 2'b10, 4), 1, 0, 32'hf8100000, 4'h0);
        add(1, enc_reg(al, `ARM_DP_OP_MOV, 0, 0, 0, 13, 2'b01, 4), 1, 0, 32'h08100000, 4'h0);
        add(1, enc_reg(al, `ARM_DP_OP_MOV, 0, 0, 0, 12, 2'b11, 4), 1, 0, 32'h10000008, 4'h0);
        add(1, enc_reg(al, `ARM_DP_OP_MOV, 0, 0, 0, 13, 2'b10, 0), 1, 0, 32'h81000000, 4'h0);
        add(1, enc_reg(al, `ARM_DP_OP_ADD, 0, 0, 1, 12, 2'b11, 8), 1, 0, 32'h8100005a, 4'h0);
        // 28..39 compare and conditional execution
        add(1, enc_imm(al, `ARM_DP_OP_CMP, 0, 0, 1, 8'h5a), 0, 0, '0, 4'h6);
        add(1, enc_imm(`ARM_DP_COND_EQ, `ARM_DP_OP_MOV, 0, 0, 0, 8'h01), 1, 0, 32'h1, 4'h6);
        add(1, enc_imm(`ARM_DP_COND_NE, `ARM_DP_OP_MOV, 0, 0, 0, 8'h02), 0, 0, '0, 4'h6);
        add(1, enc_imm(`ARM_DP_COND_CS, `ARM_DP_OP_MOV, 0, 0, 0, 8'h03), 1, 0, 32'h3, 4'h6);
        add(1, enc_imm(`ARM_DP_COND_MI, `ARM_DP_OP_MOV, 0, 0, 0, 8'h04), 0, 0, '0, 4'h6);
        add(1, enc_imm(al, `ARM_DP_OP_CMP, 0, 0, 2, 8'h10), 0, 0, '0, 4'h8);
        add(1, enc_imm(`ARM_DP_COND_MI, `ARM_DP_OP_MOV, 0, 0, 0, 8'h05), 1, 0, 32'h5, 4'h8);
        add(1, enc_imm(`ARM_DP_COND_GT, `ARM_DP_OP_MOV, 0, 0, 0, 8'h06), 0, 0, '0, 4'h8);
        add(1, enc_imm(`ARM_DP_COND_LE, `ARM_DP_OP_MOV, 0, 0, 0, 8'h07), 1, 0, 32'h7, 4'h8);
        add(1, enc_imm(al, `ARM_DP_OP_MOV, 0, 0, 0, 8'h08), 1, 0, 32'h8, 4'h8);
        add(1, enc_imm(4'hf, `ARM_DP_OP_MOV, 0, 0, 0, 8'h09), 0, 0, '0, 4'h8);
        add(1, enc_imm(`ARM_DP_COND_CC, `ARM_DP_OP_MOV, 0, 0, 0, 8'h0a), 1, 0, 32'ha, 4'h8);
    endtask

    task automatic fill_random(input int count);
        opcode_t ops [7];
        logic    v;
        word_t   ins;
        int      sel;
        ops = '{`ARM_DP_OP_AND, `ARM_DP_OP_EOR, `ARM_DP_OP_SUB, `ARM_DP_OP_ADD,
                `ARM_DP_OP_ORR, `ARM_DP_OP_MOV, `ARM_DP_OP_CMP};
        for (int i = 0; i < 16; i++) model_regs[i] = '0;
        model_flags = '0;
        for (int i = 0; i < count; i++) begin
            v = (rand_bits(2) != 0);
            sel = int'(rand_bits(3)) % 7;
            ins = rand_bits(32);
            // random condition, S, register and shift fields
            // opcode from the kept set and bit 4 cleared
            ins[27:26] = 2'b00;
            ins[24:21] = ops[sel];
            ins[4] = 1'b0;
            if (ins[25]) ins[11:8] = 4'h0;
            model_exec(v, ins);
        end
    endtask

    ////////////////////
    // main sequence
    initial begin
        clk = 1'b0;
        lfsr = 32'h6a0c;
        errors = 0;
        checks = 0;
        tests_run = 0;
        apply_reset();
        fill_table();
        run_block(0, 6, "reset_idle");
        run_block(6, 7, "imm_ops");
        run_block(13, 5, "dependency");
        run_block(18, 10, "shifts");
        run_block(28, 12, "conditions");
        apply_reset();
        tbl_count = 0;
        fill_random(RAND_COUNT);
        run_block(0, RAND_COUNT, "random");
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // watchdog for the whole run
    initial begin
        for (int i = 0; i < 5000; i++) begin
            @(posedge clk);
        end
        $display("timeout, the test sequence did not complete");
        $display("TESTS FAILED");
        $finish;
    end

endmodule
